//--- rtl/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int LINE_BYTES     = 16;
    localparam int OFFS_W         = 4;
    localparam int IDX_W          = 6;
    localparam int SETS           = 64;
    localparam int TAG_W          = 22;
    localparam int WORDS_PER_LINE = 4;

    localparam logic [1:0] BAD_BUS = 2'b10;  // bit 1 of pa_bad / resp.bad

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [TAG_W-1:0]        tag_t;

    typedef struct packed {
        logic                vld;
        logic                wr;
        logic                bypass;
        logic                flush;
        logic [ADDR_W-1:0]   vaddr;
        logic [DATA_W-1:0]   wdata;
        logic [DATA_W/8-1:0] byte_en;
    } core_req_t;

    // arrives with or after the request, held until resp.vld
    typedef struct packed {
        logic              pa_vld;
        logic [ADDR_W-1:0] paddr;
        logic [1:0]        pa_bad;  // [0] page fault, [1] bus error
    } core_xlat_t;

    typedef struct packed {
        logic              vld;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        bad;
    } core_resp_t;

endpackage

//--- rtl/axi_pkg.sv
package axi_pkg;

    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [2:0] SIZE_WORD   = 3'h2;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic [9:0]  id;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic [9:0]  id;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic [9:0]  id;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [9:0] id;
    } axi_b_t;

endpackage

//--- rtl/sp_sram.sv
`timescale 1ns/1ps

module sp_sram #(
    parameter type word_t = logic [31:0],
    parameter int  LANES  = 4,
    parameter int  DEPTH  = 64
) (
    input  logic                        clk,
    input  logic                        cs,
    input  logic                        we,
    input  logic [cache_pkg::IDX_W-1:0] addr,
    input  logic [LANES-1:0]            lane_en,
    input  word_t                       wdata,
    output word_t                       rdata
);

    word_t mem [DEPTH];

    // rdata holds its value while cs is low
    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_en[i]) begin
                    mem[addr][i*($bits(word_t)/LANES) +: $bits(word_t)/LANES] <=
                        wdata[i*($bits(word_t)/LANES) +: $bits(word_t)/LANES];
                end
            end
        end else if (cs) begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- rtl/l1_cache_ctrl.sv
`timescale 1ns/1ps

module l1_cache_ctrl (
    input  logic                             clk,
    input  logic                             rstn,
    input  cache_pkg::core_req_t             req,
    input  cache_pkg::core_xlat_t            xlat,
    output cache_pkg::core_resp_t            resp,
    output logic                             busy,
    output axi_pkg::axi_ar_t                 ar,
    output logic                             arvalid,
    input  logic                             arready,
    input  axi_pkg::axi_r_t                  r,
    input  logic                             rvalid,
    output axi_pkg::axi_aw_t                 aw,
    output logic                             awvalid,
    input  logic                             awready,
    output axi_pkg::axi_w_t                  w,
    output logic                             wvalid,
    input  logic                             wready,
    input  axi_pkg::axi_b_t                  b,
    input  logic                             bvalid,
    output logic                             tag_cs,
    output logic                             tag_we,
    output logic [cache_pkg::IDX_W-1:0]      tag_addr,
    output cache_pkg::tag_t                  tag_wdata,
    input  cache_pkg::tag_t                  tag_rdata,
    output logic                             data_cs,
    output logic                             data_we,
    output logic [cache_pkg::IDX_W-1:0]      data_addr,
    output logic [cache_pkg::LINE_BYTES-1:0] data_lane_en,
    output cache_pkg::line_t                 data_wdata,
    input  cache_pkg::line_t                 data_rdata
);

    import cache_pkg::*;
    import axi_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CMP,
        S_MREQ,
        S_REFILL,
        S_WRITE,
        S_BYP
    } state_e;

    state_e state;
    state_e state_nxt;

    logic [SETS-1:0]       valid_q;
    logic [ADDR_W-1:0]     vaddr_q;
    logic [ADDR_W-1:0]     paddr_q;
    logic [DATA_W-1:0]     wdata_q;
    logic [DATA_W/8-1:0]   be_q;
    logic                  wr_q;
    logic                  byp_q;
    logic                  ar_pend;
    logic                  aw_pend;
    logic                  w_pend;
    logic                  err_q;
    logic [1:0]            beat_q;
    logic [LINE_BYTES-1:0] refill_mask;
    logic [DATA_W-1:0]     rword_q;
    core_resp_t            resp_q;
    core_resp_t            resp_d;

    logic                  accept;
    logic [IDX_W-1:0]      idx_q;
    logic [1:0]            word_q;
    logic                  hit;
    logic                  r_last;
    logic                  r_err;
    logic                  fill_ok;
    logic [DATA_W-1:0]     r_word;

    assign accept  = (state == S_IDLE) && req.vld;
    assign idx_q   = vaddr_q[OFFS_W +: IDX_W];
    assign word_q  = vaddr_q[OFFS_W-1:2];
    assign hit     = valid_q[idx_q] && (tag_rdata == xlat.paddr[ADDR_W-1 -: TAG_W]);
    assign r_last  = rvalid && r.last;  // rready is tied high
    assign r_err   = rvalid && r.resp[1];
    assign fill_ok = (state == S_REFILL) && r_last && !(err_q || r_err);
    assign r_word  = (beat_q == word_q) ? r.data : rword_q;  // last beat may be the one

    assign busy = (state != S_IDLE);
    assign resp = resp_q;

    // arrays are read at acceptance, then addressed from the latch
    assign tag_addr  = (state == S_IDLE) ? req.vaddr[OFFS_W +: IDX_W] : idx_q;
    assign data_addr = (state == S_IDLE) ? req.vaddr[OFFS_W +: IDX_W] : idx_q;
    assign tag_wdata = paddr_q[ADDR_W-1 -: TAG_W];

    always_comb begin
        state_nxt    = state;
        resp_d       = '0;
        tag_cs       = 1'b0;
        tag_we       = 1'b0;
        data_cs      = 1'b0;
        data_we      = 1'b0;
        data_lane_en = '0;
        data_wdata   = {WORDS_PER_LINE{wdata_q}};
        unique case (state)
            S_IDLE: begin
                if (req.vld && req.flush) begin
                    resp_d.vld = 1'b1;  // valid bits cleared below
                end else if (req.vld) begin
                    tag_cs    = 1'b1;
                    data_cs   = 1'b1;
                    state_nxt = S_CMP;
                end
            end
            S_CMP: begin
                if (xlat.pa_vld) begin
                    if (|xlat.pa_bad) begin
                        resp_d.vld = 1'b1;
                        resp_d.bad = xlat.pa_bad;
                        state_nxt  = S_IDLE;
                    end else if (wr_q) begin
                        // merge into the resident line, memory gets it anyway
                        data_cs      = hit && !byp_q;
                        data_we      = 1'b1;
                        data_lane_en = LINE_BYTES'(be_q) << {word_q, 2'b00};
                        state_nxt    = S_WRITE;
                    end else if (byp_q) begin
                        state_nxt = S_BYP;
                    end else if (hit) begin
                        resp_d.vld   = 1'b1;
                        resp_d.rdata = data_rdata[word_q*DATA_W +: DATA_W];
                        state_nxt    = S_IDLE;
                    end else begin
                        state_nxt = S_MREQ;
                    end
                end
            end
            S_MREQ: begin
                if (arready) begin
                    state_nxt = S_REFILL;
                end
            end
            S_REFILL: begin
                data_cs      = rvalid;
                data_we      = 1'b1;
                data_lane_en = refill_mask;
                data_wdata   = {WORDS_PER_LINE{r.data}};
                tag_cs       = fill_ok;
                tag_we       = 1'b1;
                if (r_last) begin
                    resp_d.vld   = 1'b1;
                    resp_d.rdata = r_word;
                    resp_d.bad   = (err_q || r_err) ? BAD_BUS : 2'b00;
                    state_nxt    = S_IDLE;
                end
            end
            S_WRITE: begin
                if (bvalid) begin  // bready tied high
                    resp_d.vld = 1'b1;
                    resp_d.bad = b.resp[1] ? BAD_BUS : 2'b00;
                    state_nxt  = S_IDLE;
                end
            end
            S_BYP: begin
                if (r_last) begin
                    resp_d.vld   = 1'b1;
                    resp_d.rdata = r.data;
                    resp_d.bad   = r_err ? BAD_BUS : 2'b00;
                    state_nxt    = S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= S_IDLE;
            resp_q <= '0;
        end else begin
            state  <= state_nxt;
            resp_q <= resp_d;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (accept && req.flush) begin
            valid_q <= '0;
        end else if (state == S_MREQ) begin
            valid_q[idx_q] <= 1'b0;  // old line gets overwritten beat by beat
        end else if (fill_ok) begin
            valid_q[idx_q] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_q  <= 1'b0;
            byp_q <= 1'b0;
            err_q <= 1'b0;
        end else if (accept) begin
            wr_q  <= req.wr;
            byp_q <= req.bypass;
            err_q <= 1'b0;
        end else if (r_err) begin
            err_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_q      <= '0;
            refill_mask <= '0;
        end else if (state == S_MREQ) begin
            beat_q      <= '0;
            refill_mask <= LINE_BYTES'(4'hf);
        end else if (state == S_REFILL && rvalid) begin
            beat_q      <= beat_q + 2'd1;
            refill_mask <= {refill_mask[LINE_BYTES-5:0], refill_mask[LINE_BYTES-1 -: 4]};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            vaddr_q <= req.vaddr;
            wdata_q <= req.wdata;
            be_q    <= req.byte_en;
        end
        if (state == S_CMP && xlat.pa_vld) begin
            paddr_q <= xlat.paddr;
        end
        if (state == S_REFILL && rvalid && beat_q == word_q) begin
            rword_q <= r.data;  // requested word as it passes
        end
    end

    // AR, AW and W hold valid until taken
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ar_pend <= 1'b0;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            if (state == S_CMP && state_nxt == S_BYP) begin
                ar_pend <= 1'b1;
            end else if (arready) begin
                ar_pend <= 1'b0;
            end
            if (state == S_CMP && state_nxt == S_WRITE) begin
                aw_pend <= 1'b1;
                w_pend  <= 1'b1;
            end else begin
                if (awready) begin
                    aw_pend <= 1'b0;
                end
                if (wready) begin
                    w_pend <= 1'b0;
                end
            end
        end
    end

    assign arvalid  = (state == S_MREQ) || (state == S_BYP && ar_pend);
    assign ar.addr  = byp_q ? paddr_q : {paddr_q[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    assign ar.len   = byp_q ? 8'd0 : 8'(WORDS_PER_LINE - 1);
    assign ar.size  = SIZE_WORD;
    assign ar.burst = BURST_INCR;
    assign ar.id    = '0;

    assign awvalid  = aw_pend;
    assign aw.addr  = paddr_q;
    assign aw.len   = 8'd0;  // single beat
    assign aw.size  = SIZE_WORD;
    assign aw.burst = BURST_INCR;
    assign aw.id    = '0;

    assign wvalid = w_pend;
    assign w.data = wdata_q;
    assign w.strb = be_q;
    assign w.last = 1'b1;

endmodule

//--- rtl/l1_cache_top.sv
`timescale 1ns/1ps

module l1_cache_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  cache_pkg::core_req_t  req,
    input  cache_pkg::core_xlat_t xlat,
    output cache_pkg::core_resp_t resp,
    output logic                  busy,
    output axi_pkg::axi_ar_t      ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  axi_pkg::axi_r_t       r,
    input  logic                  rvalid,
    output axi_pkg::axi_aw_t      aw,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_pkg::axi_w_t       w,
    output logic                  wvalid,
    input  logic                  wready,
    input  axi_pkg::axi_b_t       b,
    input  logic                  bvalid
);

    import cache_pkg::*;

    logic                  tag_cs;
    logic                  tag_we;
    logic [IDX_W-1:0]      tag_addr;
    tag_t                  tag_wdata;
    tag_t                  tag_rdata;
    logic                  data_cs;
    logic                  data_we;
    logic [IDX_W-1:0]      data_addr;
    logic [LINE_BYTES-1:0] data_lane_en;
    line_t                 data_wdata;
    line_t                 data_rdata;

    l1_cache_ctrl i_ctrl (.*);

    sp_sram #(
        .word_t (tag_t),
        .LANES  (1),
        .DEPTH  (SETS)
    ) i_tag_ram (
        .clk     (clk),
        .cs      (tag_cs),
        .we      (tag_we),
        .addr    (tag_addr),
        .lane_en (1'b1),
        .wdata   (tag_wdata),
        .rdata   (tag_rdata)
    );

    // byte lanes so refill beats and write hits touch one word
    sp_sram #(
        .word_t (line_t),
        .LANES  (LINE_BYTES),
        .DEPTH  (SETS)
    ) i_data_ram (
        .clk     (clk),
        .cs      (data_cs),
        .we      (data_we),
        .addr    (data_addr),
        .lane_en (data_lane_en),
        .wdata   (data_wdata),
        .rdata   (data_rdata)
    );

endmodule

//--- sim/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter logic [31:0] KEY      = 32'hc3a5_0000,
    parameter logic [31:0] ERR_ADDR = 32'h0000_0300
) (
    input  logic             clk,
    input  logic             rstn,
    input  axi_pkg::axi_ar_t ar,
    input  logic             arvalid,
    output logic             arready,
    output axi_pkg::axi_r_t  r,
    output logic             rvalid,
    input  axi_pkg::axi_aw_t aw,
    input  logic             awvalid,
    output logic             awready,
    input  axi_pkg::axi_w_t  w,
    input  logic             wvalid,
    output logic             wready,
    output axi_pkg::axi_b_t  b,
    output logic             bvalid
);

    import axi_pkg::*;

    logic [31:0] mem [256];  // 1 KiB
    logic [31:0] rd_addr;
    logic [7:0]  rd_left;
    logic        rd_busy;
    logic [31:0] wr_addr;
    logic        aw_got;
    logic        w_got;
    axi_w_t      w_q;
    logic [31:0] rnd;
    int          seed = 38353;

    function automatic logic in_err_line(input logic [31:0] a);
        return a[31:4] == ERR_ADDR[31:4];
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = (32'(i) << 2) ^ KEY;
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            r       <= '0;
            rd_busy <= 1'b0;
            rd_addr <= '0;
            rd_left <= '0;
        end else begin
            rnd = $random(seed);
            rvalid <= 1'b0;
            if (arvalid && arready) begin
                rd_addr <= ar.addr;
                rd_left <= ar.len;
                rd_busy <= 1'b1;
                arready <= 1'b0;
            end else begin
                arready <= !rd_busy && rnd[0];  // random AR back-pressure
            end
            if (rd_busy) begin  // one beat per cycle, rready is tied high
                rvalid  <= 1'b1;
                r.data  <= in_err_line(rd_addr) ? 32'h0 : mem[rd_addr[9:2]];
                r.resp  <= in_err_line(rd_addr) ? RESP_SLVERR : 2'b00;
                r.id    <= '0;
                r.last  <= (rd_left == 8'd0);
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 8'd1;
                rd_busy <= (rd_left != 8'd0);
            end
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            bvalid  <= 1'b0;
            b       <= '0;
            wr_addr <= '0;
            w_q     <= '0;
        end else begin
            bvalid <= 1'b0;
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                awready <= 1'b0;
                wr_addr <= aw.addr;
            end else begin
                awready <= !aw_got;
            end
            if (wvalid && wready) begin
                w_got  <= 1'b1;
                wready <= 1'b0;
                w_q    <= w;
            end else begin
                wready <= !w_got;
            end
            if (aw_got && w_got) begin
                for (int i = 0; i < 4; i++) begin
                    if (w_q.strb[i] && !in_err_line(wr_addr)) begin
                        mem[wr_addr[9:2]][8*i +: 8] <= w_q.data[8*i +: 8];
                    end
                end
                b.resp <= in_err_line(wr_addr) ? RESP_SLVERR : 2'b00;
                b.id   <= '0;
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
        end
    end

endmodule

//--- sim/l1_cache_checker.sv
`timescale 1ns/1ps

module l1_cache_checker (
    input logic                  clk,
    input logic                  rstn,
    input cache_pkg::core_resp_t resp,
    input logic                  busy,
    input axi_pkg::axi_ar_t      ar,
    input logic                  arvalid,
    input logic                  arready,
    input axi_pkg::axi_aw_t      aw,
    input logic                  awvalid,
    input logic                  awready,
    input axi_pkg::axi_w_t       w,
    input logic                  wvalid,
    input logic                  wready,
    input logic [8*16-1:0]       name,
    input logic [31:0]           vaddr,
    input logic [31:0]           wdata,
    input logic [3:0]            byte_en,
    input logic                  exp_wr,     // one AW/W beat expected
    input logic [8:0]            exp_len,    // bit 8 set means no AR
    input logic [31:0]           exp_rdata,
    input logic [1:0]            exp_bad
);

    import axi_pkg::*;

    int errors = 0;
    int ar_seen;
    int aw_seen;

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch %0s %0s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    // sampled mid-cycle with DUT outputs settled
    always @(negedge clk) begin
        if (!rstn) begin
            ar_seen = 0;
            aw_seen = 0;
        end else begin
            if (arvalid || awvalid || wvalid) begin
                check("busy", 32'd1, 32'(busy));  // access in flight
            end
            if (arvalid && arready) begin
                ar_seen++;
                if (!exp_len[8]) begin
                    check("ar.len", 32'(exp_len[7:0]), 32'(ar.len));
                    check("ar.addr", (exp_len[7:0] == 8'd0) ? vaddr : {vaddr[31:4], 4'h0},
                          ar.addr);
                end
                check("ar.size", 32'(SIZE_WORD), 32'(ar.size));
                check("ar.burst", 32'(BURST_INCR), 32'(ar.burst));
            end
            if (awvalid && awready) begin
                aw_seen++;
                check("aw.addr", vaddr, aw.addr);
                check("aw.len", 32'd0, 32'(aw.len));
            end
            if (wvalid && wready) begin
                check("w.data", wdata, w.data);
                check("w.strb", 32'(byte_en), 32'(w.strb));
                check("w.last", 32'd1, 32'(w.last));
            end
            if (resp.vld) begin
                check("rdata", exp_rdata, resp.rdata);
                check("bad", 32'(exp_bad), 32'(resp.bad));
                check("ar count", exp_len[8] ? 32'd0 : 32'd1, ar_seen);
                check("aw count", 32'(exp_wr), aw_seen);
                ar_seen = 0;
                aw_seen = 0;
            end
        end
    end

endmodule

//--- sim/l1_cache_props.sv
`timescale 1ns/1ps

module l1_cache_props (
    input logic                  clk,
    input logic                  rstn,
    input cache_pkg::core_resp_t resp,
    input logic                  busy,
    input axi_pkg::axi_ar_t      ar,
    input logic                  arvalid,
    input logic                  arready,
    input logic                  awvalid,
    input logic                  wvalid
);

    int fails = 0;

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(ar))
    else begin
        fails++;
        $error("arvalid dropped or ar changed before arready");
    end

    resp_idle: assert property (@(posedge clk) disable iff (!rstn) !(resp.vld && busy))
    else begin
        fails++;
        $error("resp.vld raised while busy");
    end

    // one access in flight, reads and writes never overlap
    rd_wr_apart: assert property (@(posedge clk) disable iff (!rstn)
        !(arvalid && (awvalid || wvalid)))
    else begin
        fails++;
        $error("arvalid together with awvalid or wvalid");
    end

endmodule

bind l1_cache_ctrl l1_cache_props i_props (.*);

//--- sim/tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache;

    import cache_pkg::*;
    import axi_pkg::*;

    localparam logic [1:0]  OP_RD    = 2'd0;
    localparam logic [1:0]  OP_WR    = 2'd1;
    localparam logic [1:0]  OP_BYP   = 2'd2;
    localparam logic [1:0]  OP_FL    = 2'd3;
    localparam logic [8:0]  NO_AR    = 9'h100;
    localparam logic [31:0] MEM_KEY  = 32'hc3a5_0000;
    localparam int          N_TESTS  = 15;
    localparam int          WAIT_MAX = 200;

    typedef struct packed {
        logic [8*16-1:0] name;
        logic [1:0]      op;
        logic [31:0]     vaddr;
        logic [1:0]      pa_bad;
        logic [31:0]     wdata;
        logic [3:0]      byte_en;
        logic [31:0]     exp_rdata;
        logic [1:0]      exp_bad;
        logic [8:0]      exp_len;
    } entry_t;

    logic       clk = 1'b0;
    logic       rstn;
    core_req_t  req;
    core_xlat_t xlat;
    core_resp_t resp;
    logic       busy;
    axi_ar_t    ar;
    logic       arvalid;
    logic       arready;
    axi_r_t     r;
    logic       rvalid;
    axi_aw_t    aw;
    logic       awvalid;
    logic       awready;
    axi_w_t     w;
    logic       wvalid;
    logic       wready;
    axi_b_t     b;
    logic       bvalid;
    entry_t     tbl [N_TESTS];
    entry_t     cur = '0;
    int         timeouts = 0;

    always #2 clk = ~clk;

    l1_cache_top i_dut (.*);

    axi_mem_model #(.KEY(MEM_KEY)) i_mem (.*);

    l1_cache_checker i_chk (
        .*,
        .name      (cur.name),
        .vaddr     (cur.vaddr),
        .wdata     (cur.wdata),
        .byte_en   (cur.byte_en),
        .exp_wr    (cur.op == OP_WR && cur.pa_bad == 2'b00),
        .exp_len   (cur.exp_len),
        .exp_rdata (cur.exp_rdata),
        .exp_bad   (cur.exp_bad)
    );

    // memory word is its byte address xor the key
    function automatic logic [31:0] mem_pattern(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ MEM_KEY;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = nw[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic wait_idle();
        int n = 0;
        while (busy && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            timeouts++;
            $display("timeout: DUT still busy after %0d cycles", WAIT_MAX);
        end
    endtask

    // starts on a falling edge with the DUT idle
    task automatic apply_entry(input entry_t e);
        int n = 0;
        cur         = e;
        req.vld     = 1'b1;
        req.wr      = (e.op == OP_WR);
        req.bypass  = (e.op == OP_BYP);
        req.flush   = (e.op == OP_FL);
        req.vaddr   = e.vaddr;
        req.wdata   = e.wdata;
        req.byte_en = e.byte_en;
        @(negedge clk);  // accepted on the rising edge in between
        req.vld = 1'b0;
        if (e.op != OP_FL) begin
            xlat.pa_vld = 1'b1;
            xlat.paddr  = e.vaddr;
            xlat.pa_bad = e.pa_bad;
        end
        while (!resp.vld && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!resp.vld) begin
            timeouts++;
            $display("timeout: no response to request %0s", e.name);
        end
        xlat = '0;
        @(negedge clk);
    endtask

    initial begin
        tbl[0]  = '{"rd_miss", OP_RD, 32'h104, 2'b00, 32'h0, 4'h0, mem_pattern(32'h104), 2'b00,
                    9'd3};
        tbl[1]  = '{"rd_hit", OP_RD, 32'h104, 2'b00, 32'h0, 4'h0, mem_pattern(32'h104), 2'b00,
                    NO_AR};
        tbl[2]  = '{"rd_hit_w3", OP_RD, 32'h10c, 2'b00, 32'h0, 4'h0, mem_pattern(32'h10c), 2'b00,
                    NO_AR};
        tbl[3]  = '{"wr_hit", OP_WR, 32'h108, 2'b00, 32'h1122_3344, 4'b0110, 32'h0, 2'b00, NO_AR};
        tbl[4]  = '{"rd_after_wr_hit", OP_RD, 32'h108, 2'b00, 32'h0, 4'h0,
                    merge_bytes(mem_pattern(32'h108), 32'h1122_3344, 4'b0110), 2'b00, NO_AR};
        tbl[5]  = '{"wr_miss", OP_WR, 32'h204, 2'b00, 32'hdead_beef, 4'b1001, 32'h0, 2'b00, NO_AR};
        tbl[6]  = '{"rd_after_wr_miss", OP_RD, 32'h204, 2'b00, 32'h0, 4'h0,
                    merge_bytes(mem_pattern(32'h204), 32'hdead_beef, 4'b1001), 2'b00, 9'd3};
        tbl[7]  = '{"bypass", OP_BYP, 32'h148, 2'b00, 32'h0, 4'h0, mem_pattern(32'h148), 2'b00,
                    9'd0};
        // last word of the line, so it arrives on the final refill beat
        tbl[8]  = '{"rd_after_byp", OP_RD, 32'h14c, 2'b00, 32'h0, 4'h0, mem_pattern(32'h14c), 2'b00,
                    9'd3};
        tbl[9]  = '{"flush", OP_FL, 32'h0, 2'b00, 32'h0, 4'h0, 32'h0, 2'b00, NO_AR};
        tbl[10] = '{"rd_after_flush", OP_RD, 32'h104, 2'b00, 32'h0, 4'h0, mem_pattern(32'h104),
                    2'b00, 9'd3};
        tbl[11] = '{"page_fault", OP_RD, 32'h104, 2'b01, 32'h0, 4'h0, 32'h0, 2'b01, NO_AR};
        tbl[12] = '{"xlat_bus_err", OP_WR, 32'h104, 2'b10, 32'h5555_aaaa, 4'hf, 32'h0, 2'b10,
                    NO_AR};
        tbl[13] = '{"refill_err", OP_RD, 32'h308, 2'b00, 32'h0, 4'h0, 32'h0, 2'b10, 9'd3};
        tbl[14] = '{"refill_err_again", OP_RD, 32'h308, 2'b00, 32'h0, 4'h0, 32'h0, 2'b10, 9'd3};
        req  = '0;
        xlat = '0;
        rstn = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        for (int i = 0; i < N_TESTS && timeouts == 0; i++) begin
            wait_idle();
            if (timeouts == 0) begin
                apply_entry(tbl[i]);
            end
        end
        $display("errors: checker %0d, assertions %0d, timeouts %0d",
                 i_chk.errors, i_dut.i_ctrl.i_props.fails, timeouts);
        if (i_chk.errors + i_dut.i_ctrl.i_props.fails + timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/cache_pkg.sv
rtl/axi_pkg.sv
rtl/sp_sram.sv
rtl/l1_cache_ctrl.sv
rtl/l1_cache_top.sv
sim/axi_mem_model.sv
sim/l1_cache_checker.sv
sim/l1_cache_props.sv
sim/tb_l1_cache.sv

//--- Bender.yml
package:
  name: l1_cache

sources:
  - rtl/cache_pkg.sv
  - rtl/axi_pkg.sv
  - rtl/sp_sram.sv
  - rtl/l1_cache_ctrl.sv
  - rtl/l1_cache_top.sv
  - target: simulation
    files:
      - sim/axi_mem_model.sv
      - sim/l1_cache_checker.sv
      - sim/l1_cache_props.sv
      - sim/tb_l1_cache.sv
